/* imuldiv_pkg.sv */
//--------------------------------------------------------------------
// shared types for the iterative multiply/divide unit
// fixed at 32-bit operands, no other width is supported
//--------------------------------------------------------------------

package imuldiv_pkg;

  // operand width and the step counter that walks it
  localparam int data_w = 32;
  localparam int step_w = $clog2(data_w);

  //--------------------------------------------------------------------
  // operation code
  //--------------------------------------------------------------------

  typedef enum logic [1:0] {
    fn_mul  = 2'd0,
    fn_mulu = 2'd1,
    fn_div  = 2'd2,
    fn_divu = 2'd3
  } imuldiv_fn_e;

  // signed ops need magnitude and sign handling
  function automatic logic fn_is_signed(imuldiv_fn_e fn);
    return (fn == fn_mul) || (fn == fn_div);
  endfunction

  // divide ops use the shift-subtract step and the divres view
  function automatic logic fn_is_div(imuldiv_fn_e fn);
    return (fn == fn_div) || (fn == fn_divu);
  endfunction

  //--------------------------------------------------------------------
  // result word
  //--------------------------------------------------------------------

  // remainder sits in the upper word, quotient in the lower word
  typedef struct packed {
    logic [data_w-1:0] rem;
    logic [data_w-1:0] quot;
  } imuldiv_divres_s;

  // one 64-bit word, read as product for a multiply
  // and as rem/quot for a divide
  typedef union packed {
    logic [2*data_w-1:0] product;
    imuldiv_divres_s     divres;
  } imuldiv_result_u;

endpackage

/* imuldiv_operand_stage.sv */
//--------------------------------------------------------------------
// request register, holds one item
// negative signed operands are stored as two's-complement magnitudes
//--------------------------------------------------------------------

module imuldiv_operand_stage import imuldiv_pkg::*; (
  input  logic              clk,
  input  logic              reset,

  // request side
  input  logic [data_w-1:0] req_a,
  input  logic [data_w-1:0] req_b,
  input  imuldiv_fn_e       req_fn,
  input  logic              req_val,
  output logic              req_rdy,

  // towards the iterative core
  output logic              op_val,
  output logic [data_w-1:0] mag_a,
  output logic [data_w-1:0] mag_b,
  output imuldiv_fn_e       op_fn,
  output logic              neg_res,
  output logic              neg_rem,
  input  logic              op_rdy
);

  logic signed_op;
  logic neg_a;
  logic neg_b;
  logic req_go;

  // operand signs only count for signed ops
  assign signed_op = fn_is_signed(req_fn);
  assign neg_a     = signed_op && req_a[data_w-1];
  assign neg_b     = signed_op && req_b[data_w-1];

  // free when empty, or when the held item leaves this cycle
  assign req_rdy = !op_val || op_rdy;
  assign req_go  = req_val && req_rdy;

  //--------------------------------------------------------------------
  // valid bit
  //--------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      op_val <= 1'b0;
    end else if (req_go) begin
      op_val <= 1'b1;
    end else if (op_rdy) begin
      op_val <= 1'b0;
    end
  end

  //--------------------------------------------------------------------
  // payload
  //--------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (req_go) begin
      mag_a   <= neg_a ? (~req_a + 1'b1) : req_a;
      mag_b   <= neg_b ? (~req_b + 1'b1) : req_b;
      op_fn   <= req_fn;
      // quotient/product sign is the xor of the operand signs
      neg_res <= neg_a ^ neg_b;
      // remainder follows the dividend
      neg_rem <= neg_a;
    end
  end

  // a held item waits for the core and keeps its data
  a_op_hold: assert property (@(posedge clk) disable iff (reset)
    (op_val && !op_rdy) |=> (op_val && $stable(mag_a) && $stable(mag_b)));

endmodule

/* imuldiv_iter_ctrl.sv */
//--------------------------------------------------------------------
// control FSM of the iterative core
// one item at a time: load, 32 step cycles, then hold until taken
//--------------------------------------------------------------------

module imuldiv_iter_ctrl import imuldiv_pkg::*; (
  input  logic clk,
  input  logic reset,

  // from the operand stage
  input  logic op_val,
  output logic op_rdy,

  // to the result stage
  output logic core_val,
  input  logic core_rdy,

  // datapath controls
  output logic load,
  output logic step
);

  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_done = 2'd2
  } state_e;

  state_e            state;
  logic [step_w-1:0] count;
  logic              last_step;

  // final step is the one with the counter at all ones
  assign last_step = (count == {step_w{1'b1}});

  //--------------------------------------------------------------------
  // state and step counter
  //--------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      count <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (op_val) begin
            state <= st_calc;
          end
        end
        st_calc: begin
          // counter wraps to zero on the last step
          count <= count + 1'b1;
          if (last_step) begin
            state <= st_done;
          end
        end
        st_done: begin
          if (core_rdy) begin
            state <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  //--------------------------------------------------------------------
  // outputs
  //--------------------------------------------------------------------

  // accept only when idle
  assign op_rdy   = (state == st_idle);
  assign load     = op_val && op_rdy;
  // every calc cycle is a step
  assign step     = (state == st_calc);
  assign core_val = (state == st_done);

  // the only wrap is the calc to done transition
  a_count_wrap: assert property (@(posedge clk) disable iff (reset)
    (state == st_calc && last_step) |=> (state == st_done && count == '0));

  // counter rests at zero outside calc, so every calc run is 32 steps
  a_count_idle: assert property (@(posedge clk) disable iff (reset)
    (state != st_calc) |-> (count == '0));

  // result stays offered until the result stage takes it
  a_core_hold: assert property (@(posedge clk) disable iff (reset)
    (core_val && !core_rdy) |=> core_val);

endmodule

/* imuldiv_iter_dpath.sv */
//--------------------------------------------------------------------
// shared 64-bit accumulator for shift-add multiply and
// restoring shift-subtract divide, unsigned magnitudes only
//--------------------------------------------------------------------

module imuldiv_iter_dpath import imuldiv_pkg::*; (
  input  logic              clk,
  input  logic              reset,

  // from control
  input  logic              load,
  input  logic              step,

  // from the operand stage
  input  logic [data_w-1:0] mag_a,
  input  logic [data_w-1:0] mag_b,
  input  imuldiv_fn_e       op_fn,
  input  logic              neg_res,
  input  logic              neg_rem,

  // to the result stage
  output imuldiv_result_u   acc_result,
  output imuldiv_fn_e       core_fn,
  output logic              core_neg_res,
  output logic              core_neg_rem
);

  imuldiv_result_u   acc;
  logic [data_w-1:0] b_reg;

  // multiply step signals
  logic [data_w:0]   mul_sum;
  imuldiv_result_u   mul_next;

  // divide step signals
  logic [data_w:0]   rem_sh;
  logic [data_w+1:0] diff;
  imuldiv_result_u   div_next;

  //--------------------------------------------------------------------
  // multiply step, product view
  //--------------------------------------------------------------------

  // low bit of the multiplier selects whether the multiplicand is added
  // carry goes into the top bit as the word shifts right
  always_comb begin
    mul_sum = {1'b0, acc.product[2*data_w-1:data_w]}
            + {1'b0, (acc.product[0] ? b_reg : {data_w{1'b0}})};
    mul_next.product = {mul_sum, acc.product[data_w-1:1]};
  end

  //--------------------------------------------------------------------
  // divide step, divres view
  //--------------------------------------------------------------------

  // partial remainder picks up the next dividend bit from the quot field
  // subtract only when the difference is not negative
  always_comb begin
    rem_sh = {acc.divres.rem, acc.divres.quot[data_w-1]};
    diff   = {1'b0, rem_sh} - {2'b00, b_reg};
    if (!diff[data_w+1]) begin
      div_next.divres.rem  = diff[data_w-1:0];
      div_next.divres.quot = {acc.divres.quot[data_w-2:0], 1'b1};
    end else begin
      div_next.divres.rem  = rem_sh[data_w-1:0];
      div_next.divres.quot = {acc.divres.quot[data_w-2:0], 1'b0};
    end
  end

  //--------------------------------------------------------------------
  // registers
  //--------------------------------------------------------------------

  // both ops start with a in the low word and the upper word clear
  // b is the multiplicand or the divisor
  always_ff @(posedge clk) begin
    if (load) begin
      acc.product <= {{data_w{1'b0}}, mag_a};
      b_reg       <= mag_b;
    end else if (step) begin
      acc <= fn_is_div(core_fn) ? div_next : mul_next;
    end
  end

  // sideband travels with the item through the core
  always_ff @(posedge clk) begin
    if (reset) begin
      core_fn      <= fn_mul;
      core_neg_res <= 1'b0;
      core_neg_rem <= 1'b0;
    end else if (load) begin
      core_fn      <= op_fn;
      core_neg_res <= neg_res;
      core_neg_rem <= neg_rem;
    end
  end

  // after 32 steps the word holds the product or rem/quot
  assign acc_result = acc;

endmodule

/* imuldiv_result_stage.sv */
//--------------------------------------------------------------------
// sign fix-up and response register, holds one item
// quotient and remainder are negated independently
//--------------------------------------------------------------------

module imuldiv_result_stage import imuldiv_pkg::*; (
  input  logic            clk,
  input  logic            reset,

  // from the iterative core
  input  logic            core_val,
  output logic            core_rdy,
  input  imuldiv_result_u acc_result,
  input  imuldiv_fn_e     core_fn,
  input  logic            core_neg_res,
  input  logic            core_neg_rem,

  // response side
  output imuldiv_result_u resp_result,
  output logic            resp_val,
  input  logic            resp_rdy
);

  imuldiv_result_u fixed;
  logic            core_go;

  //--------------------------------------------------------------------
  // sign restore
  //--------------------------------------------------------------------

  always_comb begin
    fixed = acc_result;
    if (fn_is_div(core_fn)) begin
      // quotient sign from the operand xor
      if (core_neg_res) begin
        fixed.divres.quot = ~acc_result.divres.quot + 1'b1;
      end
      // remainder sign from the dividend
      if (core_neg_rem) begin
        fixed.divres.rem = ~acc_result.divres.rem + 1'b1;
      end
    end else if (core_neg_res) begin
      // whole 64-bit product
      fixed.product = ~acc_result.product + 1'b1;
    end
  end

  //--------------------------------------------------------------------
  // response register
  //--------------------------------------------------------------------

  // free when empty or when the response is taken this cycle
  assign core_rdy = !resp_val || resp_rdy;
  assign core_go  = core_val && core_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      resp_val <= 1'b0;
    end else if (core_go) begin
      resp_val <= 1'b1;
    end else if (resp_rdy) begin
      resp_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (core_go) begin
      resp_result <= fixed;
    end
  end

  // a stalled response is not overwritten
  a_resp_hold: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(resp_result)));

endmodule

/* imuldiv_top.sv */
//--------------------------------------------------------------------
// iterative multiply/divide unit, 32-bit operands
// up to three items in flight, results in request order
//--------------------------------------------------------------------

module imuldiv_top import imuldiv_pkg::*; (
  input  logic              clk,
  input  logic              reset,

  // request
  input  logic [data_w-1:0] req_a,
  input  logic [data_w-1:0] req_b,
  input  imuldiv_fn_e       req_fn,
  input  logic              req_val,
  output logic              req_rdy,

  // response
  output imuldiv_result_u   resp_result,
  output logic              resp_val,
  input  logic              resp_rdy
);

  // operand stage to core
  logic              op_val;
  logic              op_rdy;
  logic [data_w-1:0] mag_a;
  logic [data_w-1:0] mag_b;
  imuldiv_fn_e       op_fn;
  logic              neg_res;
  logic              neg_rem;

  // control to datapath
  logic              load;
  logic              step;

  // core to result stage
  logic              core_val;
  logic              core_rdy;
  imuldiv_result_u   acc_result;
  imuldiv_fn_e       core_fn;
  logic              core_neg_res;
  logic              core_neg_rem;

  imuldiv_operand_stage operand_stage (
    .clk     (clk),
    .reset   (reset),
    .req_a   (req_a),
    .req_b   (req_b),
    .req_fn  (req_fn),
    .req_val (req_val),
    .req_rdy (req_rdy),
    .op_val  (op_val),
    .mag_a   (mag_a),
    .mag_b   (mag_b),
    .op_fn   (op_fn),
    .neg_res (neg_res),
    .neg_rem (neg_rem),
    .op_rdy  (op_rdy)
  );

  imuldiv_iter_ctrl ctrl (
    .clk      (clk),
    .reset    (reset),
    .op_val   (op_val),
    .op_rdy   (op_rdy),
    .core_val (core_val),
    .core_rdy (core_rdy),
    .load     (load),
    .step     (step)
  );

  imuldiv_iter_dpath dpath (
    .clk          (clk),
    .reset        (reset),
    .load         (load),
    .step         (step),
    .mag_a        (mag_a),
    .mag_b        (mag_b),
    .op_fn        (op_fn),
    .neg_res      (neg_res),
    .neg_rem      (neg_rem),
    .acc_result   (acc_result),
    .core_fn      (core_fn),
    .core_neg_res (core_neg_res),
    .core_neg_rem (core_neg_rem)
  );

  imuldiv_result_stage result_stage (
    .clk          (clk),
    .reset        (reset),
    .core_val     (core_val),
    .core_rdy     (core_rdy),
    .acc_result   (acc_result),
    .core_fn      (core_fn),
    .core_neg_res (core_neg_res),
    .core_neg_rem (core_neg_rem),
    .resp_result  (resp_result),
    .resp_val     (resp_val),
    .resp_rdy     (resp_rdy)
  );

endmodule

/* imuldiv_tb_vectors.svh */
//----------------------------------------------------------------------
// request table for the multiply/divide testbench, included in its body
// divide results are {rem, quot}, products are the full 64-bit word
//----------------------------------------------------------------------

`ifndef IMULDIV_TB_VECTORS_SVH
`define IMULDIV_TB_VECTORS_SVH

// columns: operand a, operand b, operation, expected result word
typedef struct packed {
  logic [data_w-1:0] a;
  logic [data_w-1:0] b;
  imuldiv_fn_e       fn;
  imuldiv_result_u   result;
} vector_t;

localparam int n_vec = 30;

localparam vector_t vectors [n_vec] = '{
  // signed multiply, mixed signs, zero, most-negative, all-ones
  '{32'h0000_0003, 32'h0000_0007, fn_mul,  64'h0000_0000_0000_0015},
  '{32'hFFFF_FFFD, 32'h0000_0007, fn_mul,  64'hFFFF_FFFF_FFFF_FFEB},
  '{32'hFFFF_FFFB, 32'hFFFF_FFFA, fn_mul,  64'h0000_0000_0000_001E},
  '{32'h0000_0000, 32'hFFFF_FFFF, fn_mul,  64'h0000_0000_0000_0000},
  '{32'h8000_0000, 32'h8000_0000, fn_mul,  64'h4000_0000_0000_0000},
  '{32'h8000_0000, 32'hFFFF_FFFF, fn_mul,  64'h0000_0000_8000_0000},
  '{32'hFFFF_FFFF, 32'hFFFF_FFFF, fn_mul,  64'h0000_0000_0000_0001},
  '{32'h7FFF_FFFF, 32'h7FFF_FFFF, fn_mul,  64'h3FFF_FFFF_0000_0001},
  '{32'h8000_0000, 32'h0000_0001, fn_mul,  64'hFFFF_FFFF_8000_0000},
  // unsigned multiply, top bits count as magnitude
  '{32'hFFFF_FFFF, 32'hFFFF_FFFF, fn_mulu, 64'hFFFF_FFFE_0000_0001},
  '{32'h8000_0000, 32'h0000_0002, fn_mulu, 64'h0000_0001_0000_0000},
  '{32'hFFFF_FFFF, 32'h0000_0000, fn_mulu, 64'h0000_0000_0000_0000},
  '{32'h1234_5678, 32'h0000_0010, fn_mulu, 64'h0000_0001_2345_6780},
  '{32'hFFFF_FFFD, 32'h0000_0007, fn_mulu, 64'h0000_0006_FFFF_FFEB},
  // signed divide, quot sign from the xor, rem sign from the dividend
  '{32'h0000_0014, 32'h0000_0003, fn_div,  64'h0000_0002_0000_0006},
  '{32'hFFFF_FFEC, 32'h0000_0003, fn_div,  64'hFFFF_FFFE_FFFF_FFFA},
  '{32'h0000_0014, 32'hFFFF_FFFD, fn_div,  64'h0000_0002_FFFF_FFFA},
  '{32'hFFFF_FFEC, 32'hFFFF_FFFD, fn_div,  64'hFFFF_FFFE_0000_0006},
  '{32'h8000_0000, 32'hFFFF_FFFF, fn_div,  64'h0000_0000_8000_0000},
  '{32'h8000_0000, 32'h0000_0007, fn_div,  64'hFFFF_FFFE_EDB6_DB6E},
  '{32'h0000_0007, 32'h0000_0014, fn_div,  64'h0000_0007_0000_0000},
  '{32'h0000_0000, 32'hFFFF_FFFB, fn_div,  64'h0000_0000_0000_0000},
  // signed divide by zero, all-ones magnitude then the sign rules
  '{32'h0000_0005, 32'h0000_0000, fn_div,  64'h0000_0005_FFFF_FFFF},
  '{32'hFFFF_FFFB, 32'h0000_0000, fn_div,  64'hFFFF_FFFB_0000_0001},
  // unsigned divide
  '{32'hFFFF_FFFF, 32'h0000_0010, fn_divu, 64'h0000_000F_0FFF_FFFF},
  '{32'h8000_0000, 32'hFFFF_FFFF, fn_divu, 64'h8000_0000_0000_0000},
  '{32'hFFFF_FFFF, 32'hFFFF_FFFF, fn_divu, 64'h0000_0000_0000_0001},
  '{32'hFFFF_FFEC, 32'h0000_0003, fn_divu, 64'h0000_0002_5555_554E},
  '{32'h1234_5678, 32'h0000_0000, fn_divu, 64'h1234_5678_FFFF_FFFF},
  '{32'h0000_0000, 32'h0000_0000, fn_divu, 64'h0000_0000_FFFF_FFFF}
};

`endif

/* imuldiv_tb.sv */
//----------------------------------------------------------------------
// testbench for the multiply/divide unit, table driven
// resp_rdy is held low for a while, then random with a fixed seed
//----------------------------------------------------------------------

module imuldiv_tb import imuldiv_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int clk_period   = 100;
  localparam int reset_cycles = 16;
  // long enough for three items to pile up behind a stalled response
  localparam int stall_cycles = 80;

  logic              clk;
  logic              reset;
  logic [data_w-1:0] req_a;
  logic [data_w-1:0] req_b;
  imuldiv_fn_e       req_fn;
  logic              req_val;
  logic              req_rdy;
  imuldiv_result_u   resp_result;
  logic              resp_val;
  logic              resp_rdy;

  `include "imuldiv_tb_vectors.svh"

  // four times the no-stall budget of 40 cycles per request
  localparam int watchdog_ns =
    (reset_cycles + stall_cycles + n_vec * 40 * 4) * clk_period;

  // expected results in request order
  imuldiv_result_u exp_q[$];
  imuldiv_fn_e     fn_q[$];

  int              seed = 44;
  int              resp_count = 0;
  int              in_flight = 0;
  int              max_in_flight = 0;
  logic            stalled = 1'b0;
  imuldiv_result_u stall_value;
  imuldiv_result_u exp_r;
  imuldiv_fn_e     fn_r;

  imuldiv_top UUT (
    .clk         (clk),
    .reset       (reset),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_fn      (req_fn),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  initial clk = 1'b0;
  always #(clk_period / 2) clk = ~clk;

  //--------------------------------------------------------------------
  // compare tasks
  //--------------------------------------------------------------------

  task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  // the operation picks the view: rem/quot for a divide, product otherwise
  task automatic check_result(input string name, input imuldiv_fn_e fn,
                              input imuldiv_result_u exp, input imuldiv_result_u got);
    if (fn == fn_div || fn == fn_divu) begin
      if (got.divres.quot !== exp.divres.quot) begin
        stop_with_failure($sformatf("ERROR at %0t ns: %s.divres.quot expected %h got %h",
                                    $time, name, exp.divres.quot, got.divres.quot));
      end
      if (got.divres.rem !== exp.divres.rem) begin
        stop_with_failure($sformatf("ERROR at %0t ns: %s.divres.rem expected %h got %h",
                                    $time, name, exp.divres.rem, got.divres.rem));
      end
    end else if (got.product !== exp.product) begin
      stop_with_failure($sformatf("ERROR at %0t ns: %s.product expected %h got %h",
                                  $time, name, exp.product, got.product));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic got);
    if (got !== exp) begin
      stop_with_failure($sformatf("ERROR at %0t ns: %s expected %b got %b",
                                  $time, name, exp, got));
    end
  endtask

  task automatic check_count(input string name, input int exp, input int got);
    if (got != exp) begin
      stop_with_failure($sformatf("ERROR at %0t ns: %s expected %0d got %0d",
                                  $time, name, exp, got));
    end
  endtask

  //--------------------------------------------------------------------
  // response back-pressure
  //--------------------------------------------------------------------

  initial begin
    resp_rdy = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    // forced stall so the pipeline fills up
    resp_rdy = 1'b0;
    repeat (stall_cycles) @(negedge clk);
    forever begin
      resp_rdy = (($random(seed) & 3) != 0);
      @(negedge clk);
    end
  end

  //--------------------------------------------------------------------
  // monitor, samples handshakes on the rising edge
  //--------------------------------------------------------------------

  always @(posedge clk) begin
    if (!reset) begin
      // a stalled response must not move
      if (stalled) begin
        check_bit("resp_val", 1'b1, resp_val);
        check_result("resp_result", fn_q[0], stall_value, resp_result);
      end
      if (resp_val && resp_rdy) begin
        if (exp_q.size() == 0) begin
          stop_with_failure("ERROR: a response arrived with no request outstanding");
        end else begin
          exp_r = exp_q.pop_front();
          fn_r  = fn_q.pop_front();
          check_result("resp_result", fn_r, exp_r, resp_result);
          resp_count++;
        end
      end
      in_flight = in_flight + int'(req_val && req_rdy) - int'(resp_val && resp_rdy);
      if (in_flight > 3) begin
        stop_with_failure("ERROR: more than three operations were accepted at once");
      end
      if (in_flight > max_in_flight) begin
        max_in_flight = in_flight;
      end
      stalled     = resp_val && !resp_rdy;
      stall_value = resp_result;
    end
  end

  //--------------------------------------------------------------------
  // watchdog
  //--------------------------------------------------------------------

  initial begin
    #(watchdog_ns);
    stop_with_failure($sformatf("ERROR: responses stopped arriving, %0d of %0d received",
                                resp_count, n_vec));
  end

  //--------------------------------------------------------------------
  // driver
  //--------------------------------------------------------------------

  initial begin
    reset   = 1'b1;
    req_val = 1'b0;
    req_a   = '0;
    req_b   = '0;
    req_fn  = fn_mul;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // idle levels right after reset
    check_bit("resp_val", 1'b0, resp_val);
    check_bit("req_rdy", 1'b1, req_rdy);

    // back to back, next request goes out right after each accept
    for (int i = 0; i < n_vec; i++) begin
      @(negedge clk);
      req_a   = vectors[i].a;
      req_b   = vectors[i].b;
      req_fn  = vectors[i].fn;
      req_val = 1'b1;
      exp_q.push_back(vectors[i].result);
      fn_q.push_back(vectors[i].fn);
      while (!req_rdy) begin
        @(negedge clk);
      end
      @(posedge clk);
    end
    @(negedge clk);
    req_val = 1'b0;

    wait (resp_count == n_vec);
    // extra time to catch a duplicated response
    repeat (40) @(posedge clk);
    check_count("peak operations in flight", 3, max_in_flight);
    $display("TESTS PASSED");
    $finish;
  end

endmodule

/* all.f */
+incdir+.
imuldiv_pkg.sv
imuldiv_operand_stage.sv
imuldiv_iter_ctrl.sv
imuldiv_iter_dpath.sv
imuldiv_result_stage.sv
imuldiv_top.sv
imuldiv_tb.sv
